// ==== Makefile ====
# Verilator build and run of the error tracker testbench.

VERILATOR ?= verilator
TOP       ?= tb_errt
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= >>> PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS RUN_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	@out=$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q -F -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/errt_assertions.sv ====
`timescale 1ns/1ps

module errt_assertions (
    input logic                clk,
    input logic                rstb,
    input logic                dbg_req_valid_i,
    input errt_pkg::dbg_req_t  dbg_req_i,
    input logic                dbg_req_ready_o,
    input logic                dbg_resp_valid_o,
    input errt_pkg::dbg_resp_t dbg_resp_o,
    input logic                dbg_resp_ready_i,
    input errt_pkg::count_t    count_i
);
    import errt_pkg::*;

    // Number of assertion failures seen so far.
    int unsigned fail_count = 0;

    // Coming out of a reset cycle the response side is idle and a request can be taken.
    assert property (@(posedge clk) !rstb |=> (!dbg_resp_valid_o && dbg_req_ready_o))
    else begin
        $error("response valid or request not ready after a reset cycle");
        fail_count++;
    end

    assert property (@(posedge clk) disable iff (!rstb)
        (dbg_resp_valid_o && !dbg_resp_ready_i) |=>
        (dbg_resp_valid_o && $stable(dbg_resp_o)))
    else begin
        $error("response dropped or changed while waiting for ready");
        fail_count++;
    end

    assert property (@(posedge clk) disable iff (!rstb)
        (dbg_req_valid_i && !dbg_req_ready_o) |=>
        (dbg_req_valid_i && $stable(dbg_req_i)))
    else begin
        $error("request dropped or changed while waiting for ready");
        fail_count++;
    end

    // An accepted request has its response pending from the next edge.
    assert property (@(posedge clk) disable iff (!rstb)
        (dbg_req_valid_i && dbg_req_ready_o) |=> dbg_resp_valid_o)
    else begin
        $error("no response pending on the edge after a request was accepted");
        fail_count++;
    end

    // Taking the response frees the request side for the next one.
    assert property (@(posedge clk) disable iff (!rstb)
        (dbg_resp_valid_o && dbg_resp_ready_i) |=> dbg_req_ready_o)
    else begin
        $error("request ready still low after the response was taken");
        fail_count++;
    end

    assert property (@(posedge clk) disable iff (!rstb) count_i <= count_t'(DEPTH))
    else begin
        $error("capture count above the memory depth");
        fail_count++;
    end

endmodule

bind error_capture_core errt_assertions u_assert (
    .clk              (clk),
    .rstb             (rstb),
    .dbg_req_valid_i  (dbg_req_valid_i),
    .dbg_req_i        (dbg_req_i),
    .dbg_req_ready_o  (dbg_req_ready_o),
    .dbg_resp_valid_o (dbg_resp_valid_o),
    .dbg_resp_o       (dbg_resp_o),
    .dbg_resp_ready_i (dbg_resp_ready_i),
    .count_i          (count_q)
);

// ==== bench/tb_errt.sv ====
`timescale 1ns/1ps

module tb_errt;
    import errt_pkg::*;

    localparam int          WIN_BITS   = $bits(window_t);
    localparam int          MAX_CYCLES = 4000;
    localparam logic [31:0] SEED       = 32'h8de5d83a;

    typedef logic [WIN_BITS-1:0] wide_t;

    logic      clk = 1'b0;
    logic      rstb;
    frame_t    frame;
    logic      req_valid;
    dbg_req_t  req;
    logic      req_ready;
    logic      resp_valid;
    dbg_resp_t resp;
    logic      resp_ready;

    logic        inject;
    int unsigned stall_draw = 0;
    int          cycles = 0;
    int          errors = 0;
    int          err_at_start = 0;
    int          passed = 0;
    int          failed = 0;
    int unsigned assert_fails;

    // Expected windows in capture order, as the debug port should return them.
    window_t exp_q[$];
    frame_t  m_prev1;
    frame_t  m_prev2;
    window_t model_win;

    errt_subsystem dut (
        .clk              (clk),
        .rstb             (rstb),
        .frame_i          (frame),
        .dbg_req_valid_i  (req_valid),
        .dbg_req_i        (req),
        .dbg_req_ready_o  (req_ready),
        .dbg_resp_valid_o (resp_valid),
        .dbg_resp_o       (resp),
        .dbg_resp_ready_i (resp_ready)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic frame_t random_frame(input logic flagged);
        frame_t      f;
        logic [31:0] r;
        r = $urandom;
        f.bits = r[15:0];
        f.prbs_flags = '0;
        if (flagged) begin
            f.prbs_flags = r[31:16];
            if (r[31:16] == 16'h0000) begin
                f.prbs_flags = 16'h0001;
            end
        end
        f.sd_flags = $urandom;
        f.est_error = {$urandom, $urandom, $urandom, $urandom};
        return f;
    endfunction

    // All random numbers come from this one process.
    initial begin
        void'($urandom(SEED));
        frame = '0;
        forever begin
            @(posedge clk);
            frame      <= random_frame(inject);
            stall_draw <= $urandom_range(8, 1);
        end
    end

    // A flagged frame yields the window of the frame before, itself and the frame after.
    always @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            m_prev1 = '0;
            m_prev2 = '0;
            exp_q.delete();
        end else begin
            if (req_valid && req_ready && req.op == DBG_CLEAR) begin
                exp_q.delete();
            end
            if (|m_prev1.prbs_flags && exp_q.size() < DEPTH) begin
                model_win[0] = frame;
                model_win[1] = m_prev1;
                model_win[2] = m_prev2;
                exp_q.push_back(model_win);
            end
            m_prev2 = m_prev1;
            m_prev1 = frame;
        end
    end

    task automatic expect_eq(input string name, input wide_t got, input wide_t exp);
        assert (got === exp) else begin
            $display("[FAIL] %0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic inject_flags(input int n);
        @(posedge clk);
        inject <= 1'b1;
        repeat (n) @(posedge clk);
        inject <= 1'b0;
    endtask

    task automatic send_req(input dbg_op_e op, input addr_t addr);
        @(posedge clk);
        req_valid <= 1'b1;
        req.op    <= op;
        req.addr  <= addr;
        do begin
            @(posedge clk);
        end while (!req_ready);
        req_valid <= 1'b0;
    endtask

    task automatic take_resp(input int stall, output dbg_resp_t r);
        do begin
            @(posedge clk);
        end while (!resp_valid);
        repeat (stall) @(posedge clk);
        resp_ready <= 1'b1;
        @(posedge clk);
        r = resp;
        resp_ready <= 1'b0;
    endtask

    task automatic transact(input dbg_op_e op, input addr_t addr, output dbg_resp_t r);
        send_req(op, addr);
        take_resp(0, r);
    endtask

    // Count, full flag and every read address checked against the expected windows.
    task automatic compare_contents(input int n_addr);
        dbg_resp_t r;
        int        size;
        size = exp_q.size();
        transact(DBG_COUNT, '0, r);
        expect_eq("dbg_resp_o.count", wide_t'(r.count), wide_t'(size));
        expect_eq("dbg_resp_o.full", wide_t'(r.full), wide_t'(size == DEPTH));
        expect_eq("dbg_resp_o.hit", wide_t'(r.hit), wide_t'(0));
        for (int a = 0; a < n_addr; a++) begin
            transact(DBG_READ, addr_t'(a), r);
            if (a < size) begin
                expect_eq($sformatf("dbg_resp_o.hit @%0d", a), wide_t'(r.hit), wide_t'(1));
                expect_eq($sformatf("dbg_resp_o.window @%0d", a), wide_t'(r.window),
                          wide_t'(exp_q[a]));
            end else begin
                expect_eq($sformatf("dbg_resp_o.hit @%0d", a), wide_t'(r.hit), wide_t'(0));
                expect_eq($sformatf("dbg_resp_o.window @%0d", a), wide_t'(r.window), '0);
            end
        end
    endtask

    task automatic start_test();
        err_at_start = errors;
    endtask

    task automatic report_test(input string name);
        if (errors == err_at_start) begin
            $display("test %s: ok", name);
            passed++;
        end else begin
            $display("test %s: %0d mismatches", name, errors - err_at_start);
            failed++;
        end
    endtask

    task automatic after_reset();
        start_test();
        compare_contents(1);
        report_test("after_reset");
    endtask

    task automatic isolated_triggers();
        start_test();
        for (int i = 0; i < 6; i++) begin
            inject_flags(1);
            idle(5);
        end
        idle(4);
        compare_contents(exp_q.size() + 2);
        report_test("isolated_triggers");
    endtask

    task automatic adjacent_triggers();
        dbg_resp_t first;
        dbg_resp_t second;
        int        n;
        start_test();
        n = exp_q.size();
        inject_flags(2);
        idle(6);
        expect_eq("expected window count", wide_t'(exp_q.size()), wide_t'(n + 2));
        compare_contents(exp_q.size() + 1);
        // The two windows share the flagged frames, shifted by one position.
        transact(DBG_READ, addr_t'(n), first);
        transact(DBG_READ, addr_t'(n + 1), second);
        expect_eq("window[0] vs next window[1]", wide_t'(first.window[0]),
                  wide_t'(exp_q[n + 1][1]));
        expect_eq("window[1] vs next window[2]", wide_t'(first.window[1]),
                  wide_t'(exp_q[n + 1][2]));
        expect_eq("next window[1] vs window[0]", wide_t'(second.window[1]),
                  wide_t'(exp_q[n][0]));
        expect_eq("next window[2] vs window[1]", wide_t'(second.window[2]),
                  wide_t'(exp_q[n][1]));
        report_test("adjacent_triggers");
    endtask

    task automatic stalled_response();
        dbg_resp_t first;
        dbg_resp_t second;
        int        size_before;
        int        stall;
        start_test();
        size_before = exp_q.size();
        send_req(DBG_COUNT, '0);
        do begin
            @(posedge clk);
        end while (!resp_valid);
        inject_flags(1);
        idle(3);
        inject_flags(1);
        idle(4);
        // A second request waits behind the pending response.
        req_valid <= 1'b1;
        req.op    <= DBG_COUNT;
        req.addr  <= '0;
        stall = stall_draw;
        repeat (stall) begin
            @(posedge clk);
            expect_eq("dbg_req_ready_o", wide_t'(req_ready), wide_t'(0));
        end
        resp_ready <= 1'b1;
        @(posedge clk);
        first = resp;
        resp_ready <= 1'b0;
        do begin
            @(posedge clk);
        end while (!req_ready);
        req_valid <= 1'b0;
        take_resp(stall, second);
        expect_eq("dbg_resp_o.count", wide_t'(first.count), wide_t'(size_before));
        expect_eq("expected window count", wide_t'(exp_q.size()), wide_t'(size_before + 2));
        expect_eq("dbg_resp_o.count", wide_t'(second.count), wide_t'(exp_q.size()));
        report_test("stalled_response");
    endtask

    task automatic overflow_drops();
        dbg_resp_t r;
        start_test();
        for (int i = 0; i < DEPTH + 4; i++) begin
            inject_flags(1);
            idle(2);
        end
        idle(6);
        transact(DBG_COUNT, '0, r);
        expect_eq("dbg_resp_o.count", wide_t'(r.count), wide_t'(DEPTH));
        expect_eq("dbg_resp_o.full", wide_t'(r.full), wide_t'(1));
        compare_contents(DEPTH);
        report_test("overflow_drops");
    endtask

    task automatic clear_and_refill();
        dbg_resp_t r;
        int        old_size;
        start_test();
        old_size = exp_q.size();
        transact(DBG_CLEAR, '0, r);
        expect_eq("dbg_resp_o.count", wide_t'(r.count), wide_t'(old_size));
        expect_eq("dbg_resp_o.full", wide_t'(r.full), wide_t'(old_size == DEPTH));
        expect_eq("dbg_resp_o.hit", wide_t'(r.hit), wide_t'(0));
        expect_eq("dbg_resp_o.window", wide_t'(r.window), '0);
        transact(DBG_COUNT, '0, r);
        expect_eq("dbg_resp_o.count", wide_t'(r.count), wide_t'(0));
        expect_eq("dbg_resp_o.full", wide_t'(r.full), wide_t'(0));
        transact(DBG_READ, addr_t'(0), r);
        expect_eq("dbg_resp_o.hit", wide_t'(r.hit), wide_t'(0));
        transact(DBG_READ, addr_t'(DEPTH - 1), r);
        expect_eq("dbg_resp_o.hit", wide_t'(r.hit), wide_t'(0));
        for (int i = 0; i < 3; i++) begin
            inject_flags(1);
            idle(4);
        end
        idle(4);
        expect_eq("expected window count", wide_t'(exp_q.size()), wide_t'(3));
        compare_contents(4);
        report_test("clear_and_refill");
    endtask

    initial begin
        rstb       = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        resp_ready = 1'b0;
        inject     = 1'b0;
        repeat (4) @(posedge clk);
        rstb <= 1'b1;
        idle(2);

        after_reset();
        isolated_triggers();
        adjacent_triggers();
        stalled_response();
        overflow_drops();
        clear_and_refill();

        idle(2);
        assert_fails = dut.u_tracker.u_core.u_assert.fail_count;
        $display("Tests passed %0d, failed %0d, assertion failures %0d",
                 passed, failed, assert_fails);
        if (failed == 0 && assert_fails == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
verilog/errt_pkg.sv
verilog/frame_history.sv
verilog/error_capture_core.sv
verilog/error_tracker.sv
verilog/errt_subsystem.sv
bench/errt_assertions.sv
bench/tb_errt.sv

// ==== verilog/error_capture_core.sv ====
`timescale 1ns/1ps

module error_capture_core (
    input  logic                clk,
    input  logic                rstb,

    input  logic                capture_en_i,
    input  errt_pkg::window_t   window_i,

    input  logic                dbg_req_valid_i,
    input  errt_pkg::dbg_req_t  dbg_req_i,
    output logic                dbg_req_ready_o,

    output logic                dbg_resp_valid_o,
    output errt_pkg::dbg_resp_t dbg_resp_o,
    input  logic                dbg_resp_ready_i
);
    import errt_pkg::*;

    window_t          mem [DEPTH];
    logic [DEPTH-1:0] valid_q;
    addr_t            wr_ptr_q;
    count_t           count_q;
    logic             full;

    logic             req_fire;
    logic             resp_fire;
    logic             clear_fire;
    logic             capture_fire;

    logic             resp_valid_q;
    dbg_resp_t        resp_q;
    dbg_resp_t        resp_d;

    assign full = (count_q == count_t'(DEPTH));

    // Only one request may be outstanding at a time.
    assign dbg_req_ready_o  = !resp_valid_q;
    assign dbg_resp_valid_o = resp_valid_q;
    assign dbg_resp_o       = resp_q;

    assign req_fire   = dbg_req_valid_i && dbg_req_ready_o;
    assign resp_fire  = resp_valid_q && dbg_resp_ready_i;
    assign clear_fire = req_fire && (dbg_req_i.op == DBG_CLEAR);

    // A trigger is dropped when the memory is full or a clear lands on the same edge.
    assign capture_fire = capture_en_i && !full && !clear_fire;

    always_ff @(posedge clk) begin
        if (capture_fire) begin
            mem[wr_ptr_q] <= window_i;
        end
    end

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            valid_q  <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (clear_fire) begin
            valid_q  <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (capture_fire) begin
            valid_q[wr_ptr_q] <= 1'b1;
            wr_ptr_q          <= wr_ptr_q + addr_t'(1);
            count_q           <= count_q + count_t'(1);
        end
    end

    // The response reflects the state seen at the accepting edge, so a
    // clear reports the count and full flag it is about to discard.
    always_comb begin
        resp_d       = '0;
        resp_d.count = count_q;
        resp_d.full  = full;
        case (dbg_req_i.op)
            DBG_READ: begin
                resp_d.hit = valid_q[dbg_req_i.addr];
                if (valid_q[dbg_req_i.addr]) begin
                    resp_d.window = mem[dbg_req_i.addr];
                end
            end
            default: begin
                resp_d.hit = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            resp_valid_q <= 1'b0;
        end else if (req_fire) begin
            resp_valid_q <= 1'b1;
        end else if (resp_fire) begin
            resp_valid_q <= 1'b0;
        end
    end

    // Held unchanged until the response is taken.
    always_ff @(posedge clk) begin
        if (req_fire) begin
            resp_q <= resp_d;
        end
    end

endmodule

// ==== verilog/error_tracker.sv ====
`timescale 1ns/1ps

module error_tracker (
    input  logic                clk,
    input  logic                rstb,
    input  errt_pkg::frame_t    frame_i,

    input  logic                dbg_req_valid_i,
    input  errt_pkg::dbg_req_t  dbg_req_i,
    output logic                dbg_req_ready_o,

    output logic                dbg_resp_valid_o,
    output errt_pkg::dbg_resp_t dbg_resp_o,
    input  logic                dbg_resp_ready_i
);
    import errt_pkg::*;

    window_t window;
    logic    trigger_q;

    frame_history u_history (
        .clk      (clk),
        .rstb     (rstb),
        .frame_i  (frame_i),
        .window_o (window)
    );

    // One clock after the flagged frame enters the window it has moved to
    // index 1, with its neighbours on either side.
    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            trigger_q <= 1'b0;
        end else begin
            trigger_q <= |window[0].prbs_flags;
        end
    end

    error_capture_core u_core (
        .clk              (clk),
        .rstb             (rstb),
        .capture_en_i     (trigger_q),
        .window_i         (window),
        .dbg_req_valid_i  (dbg_req_valid_i),
        .dbg_req_i        (dbg_req_i),
        .dbg_req_ready_o  (dbg_req_ready_o),
        .dbg_resp_valid_o (dbg_resp_valid_o),
        .dbg_resp_o       (dbg_resp_o),
        .dbg_resp_ready_i (dbg_resp_ready_i)
    );

endmodule

// ==== verilog/errt_pkg.sv ====
package errt_pkg;

    // Frame geometry as delivered by the slicer and the PRBS checker.
    localparam int LANES      = 16;
    localparam int ERR_BW     = 8;

    // Capture memory geometry.
    localparam int ADDR_W     = 5;
    localparam int DEPTH      = 2 ** ADDR_W;
    localparam int CNT_W      = ADDR_W + 1;

    // One frame before the flag, the flagged frame and one after it.
    localparam int WIN_FRAMES = 3;

    typedef logic [LANES-1:0]        lane_vec_t;
    typedef logic signed [ERR_BW-1:0] err_t;
    typedef logic [ADDR_W-1:0]       addr_t;
    typedef logic [CNT_W-1:0]        count_t;

    // Lane n sits at bit n of the flag and bit vectors, at sd_flags[n]
    // and at est_error[n].
    typedef struct packed {
        lane_vec_t               prbs_flags;
        lane_vec_t               bits;
        logic [LANES-1:0][1:0]   sd_flags;
        err_t [LANES-1:0]        est_error;
    } frame_t;

    // Index 0 is the newest frame, index WIN_FRAMES-1 the oldest.
    typedef frame_t [WIN_FRAMES-1:0] window_t;

    typedef enum logic [1:0] {
        DBG_READ  = 2'd0,
        DBG_COUNT = 2'd1,
        DBG_CLEAR = 2'd2
    } dbg_op_e;

    typedef struct packed {
        dbg_op_e op;
        addr_t   addr;
    } dbg_req_t;

    // hit is set only for a read of an entry that holds a window.
    typedef struct packed {
        logic    hit;
        count_t  count;
        logic    full;
        window_t window;
    } dbg_resp_t;

endpackage

// ==== verilog/errt_subsystem.sv ====
`timescale 1ns/1ps

module errt_subsystem (
    input  logic                clk,
    input  logic                rstb,
    input  errt_pkg::frame_t    frame_i,

    input  logic                dbg_req_valid_i,
    input  errt_pkg::dbg_req_t  dbg_req_i,
    output logic                dbg_req_ready_o,

    output logic                dbg_resp_valid_o,
    output errt_pkg::dbg_resp_t dbg_resp_o,
    input  logic                dbg_resp_ready_i
);

    // Frames arrive every clock with no handshake. The debug port is the
    // only path to the captured windows and the count.
    error_tracker u_tracker (
        .clk              (clk),
        .rstb             (rstb),
        .frame_i          (frame_i),
        .dbg_req_valid_i  (dbg_req_valid_i),
        .dbg_req_i        (dbg_req_i),
        .dbg_req_ready_o  (dbg_req_ready_o),
        .dbg_resp_valid_o (dbg_resp_valid_o),
        .dbg_resp_o       (dbg_resp_o),
        .dbg_resp_ready_i (dbg_resp_ready_i)
    );

endmodule

// ==== verilog/frame_history.sv ====
`timescale 1ns/1ps

module frame_history (
    input  logic               clk,
    input  logic               rstb,
    input  errt_pkg::frame_t   frame_i,
    output errt_pkg::window_t  window_o
);
    import errt_pkg::*;

    // Stage 0 takes the incoming frame, each later stage is one clock older.
    frame_t stage_q [WIN_FRAMES];

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            for (int i = 0; i < WIN_FRAMES; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= frame_i;
            for (int i = 1; i < WIN_FRAMES; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    // The window index follows the stage number, so index 0 is the newest.
    always_comb begin
        for (int i = 0; i < WIN_FRAMES; i++) begin
            window_o[i] = stage_q[i];
        end
    end

endmodule
